// File: src/adcSerialPkg.sv
`default_nettype none

// serial frame format of the eight-channel 12-bit SAR converter
package adcSerialPkg;

        // one frame is sixteen serial clock periods with csN low
        localparam int frameBits = 16;

        // conversion result width, sent MSB first after four leading zeros
        localparam int sampleBits = 12;

        // channel address width and number of inputs on the converter
        localparam int channelBits = 3;
        localparam int maxChannels = 8;

        // position of address bit 2 on din, counted from the first bit sent
        // so the address sits in bits 2 to 4 and every other din bit is zero
        localparam int addressMsb = 2;

        // one conversion result
        typedef logic [sampleBits-1:0] sample_t;

        // a channel number as it travels on din
        typedef logic [channelBits-1:0] channel_t;

endpackage

`default_nettype wire

// File: src/adcScanPkg.sv
`default_nettype none

// definitions private to the scan controller
package adcScanPkg;

        // the sequencer is idle, runs back-to-back frames, or holds done
        // until go is released
        typedef enum logic [1:0] {
                scanIdle,
                scanFrame,
                scanDone
        } scanState_t;

        // counts system clock cycles within one serial clock half period
        typedef logic [7:0] dividerCount_t;

endpackage

`default_nettype wire

// File: src/sclkGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module sclkGenerator #(
        parameter int halfPeriodCycles = 4
) (
        input  logic clock,
        input  logic reset,
        input  logic csN,
        output logic sclk,
        output logic fallStrobe,
        output logic riseStrobe,
        output logic frameEnd
);
        import adcSerialPkg::*;
        import adcScanPkg::*;

        localparam dividerCount_t reloadValue = dividerCount_t'(halfPeriodCycles - 1);
        localparam int bitCountBits = $clog2(frameBits);

        dividerCount_t divider;
        logic [bitCountBits-1:0] bitCount;
        logic toggle;
        logic lastRise;

        // the shifter needs a free cycle between frameEnd and the next fall
        if (halfPeriodCycles < 2 || halfPeriodCycles > 255) begin : checkHalfPeriod
                $error("halfPeriodCycles must lie between 2 and 255");
        end

        // strobes mark the cycle whose closing edge flips sclk
        assign toggle = !csN && divider == '0;
        assign fallStrobe = toggle && sclk;
        assign riseStrobe = toggle && !sclk;

        // sixteenth rising edge of the current frame
        assign lastRise = riseStrobe && bitCount == bitCountBits'(frameBits - 1);

        // half period divider, parked at reload with sclk high while csN is high
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        divider <= reloadValue;
                        sclk <= 1'b1;
                end else if (csN) begin
                        divider <= reloadValue;
                        sclk <= 1'b1;
                end else if (divider == '0) begin
                        divider <= reloadValue;
                        sclk <= ~sclk;
                end else begin
                        divider <= divider - 1'b1;
                end
        end

        // rising edges within a frame, wrapping straight into the next frame
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        bitCount <= '0;
                        frameEnd <= 1'b0;
                end else begin
                        frameEnd <= lastRise;
                        if (csN) begin
                                bitCount <= '0;
                        end else if (riseStrobe) begin
                                bitCount <= lastRise ? '0 : bitCount + 1'b1;
                        end
                end
        end

        // csN comes from the sequencer, so this ties the two blocks together
        sclkIdleHigh: assert property (@(posedge clock) disable iff (reset)
                csN |-> sclk)
                else $error("sclk is low while csN is high");

endmodule

`default_nettype wire

// File: src/frameShifter.sv
`timescale 1ns/1ps
`default_nettype none

module frameShifter (
        input  logic clock,
        input  logic reset,
        input  logic load,
        input  adcSerialPkg::channel_t loadAddress,
        input  logic fallStrobe,
        input  logic riseStrobe,
        input  logic dout,
        output logic din,
        output adcSerialPkg::sample_t sample
);
        import adcSerialPkg::*;

        // bit frameBits-1 is the next one to go out on din
        logic [frameBits-1:0] outWord;
        logic [frameBits-1:0] loadWord;
        sample_t inWord;

        // outgoing frame with the channel address in place and zeros elsewhere
        always_comb begin
                loadWord = '0;
                loadWord[frameBits-1-addressMsb -: channelBits] = loadAddress;
        end

        // din follows each falling edge so it is stable at the next rising edge
        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        din <= 1'b0;
                end else if (fallStrobe) begin
                        din <= outWord[frameBits-1];
                end
        end

        always_ff @(posedge clock) begin
                if (load) begin
                        outWord <= loadWord;
                        inWord <= '0;
                end else begin
                        if (fallStrobe) begin
                                outWord <= {outWord[frameBits-2:0], 1'b0};
                        end
                        // only the last twelve bits of the frame survive, the
                        // four leading zeros are pushed out the top
                        if (riseStrobe) begin
                                inWord <= {inWord[sampleBits-2:0], dout};
                        end
                end
        end

        assign sample = inWord;

        // load comes from the sequencer and the strobes from the generator, a
        // collision would drop a bit of the frame
        loadApart: assert property (@(posedge clock) disable iff (reset)
                load |-> !(fallStrobe || riseStrobe))
                else $error("load coincides with a serial clock strobe");

endmodule

`default_nettype wire

// File: src/scanSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module scanSequencer #(
        parameter int numChannels = 8
) (
        input  logic clock,
        input  logic reset,
        input  logic go,
        input  logic frameEnd,
        input  adcSerialPkg::sample_t sample,
        output logic csN,
        output logic done,
        output logic load,
        output adcSerialPkg::channel_t loadAddress,
        output adcSerialPkg::sample_t readings [numChannels]
);
        import adcSerialPkg::*;
        import adcScanPkg::*;

        localparam int frameIndexBits = $clog2(maxChannels + 1);
        localparam logic [frameIndexBits-1:0] lastFrame = frameIndexBits'(numChannels);

        scanState_t state;
        logic [frameIndexBits-1:0] frameIndex;
        logic [frameIndexBits-1:0] nextIndex;
        logic storeEnable;
        channel_t storeIndex;

        if (numChannels < 1 || numChannels > maxChannels) begin : checkChannels
                $error("numChannels must lie between 1 and %0d", maxChannels);
        end

        assign csN = state != scanFrame;
        assign done = state == scanDone;
        assign nextIndex = frameIndex + 1'b1;

        // a frame returns the channel the previous frame addressed, so the
        // first frame of a scan carries no result
        assign storeEnable = state == scanFrame && frameEnd && frameIndex != '0;
        assign storeIndex = channel_t'(frameIndex - 1'b1);

        // the extra frame at the end of a scan readdresses channel 0
        always_comb begin
                load = 1'b0;
                loadAddress = '0;
                case (state)
                        scanIdle: begin
                                load = go;
                        end
                        scanFrame: begin
                                if (frameEnd && frameIndex != lastFrame) begin
                                        load = 1'b1;
                                        if (nextIndex < numChannels) begin
                                                loadAddress = channel_t'(nextIndex);
                                        end
                                end
                        end
                        default: begin
                                load = 1'b0;
                        end
                endcase
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        state <= scanIdle;
                        frameIndex <= '0;
                end else begin
                        case (state)
                                scanIdle: begin
                                        if (go) begin
                                                state <= scanFrame;
                                                frameIndex <= '0;
                                        end
                                end
                                scanFrame: begin
                                        if (frameEnd) begin
                                                if (frameIndex == lastFrame) begin
                                                        state <= scanDone;
                                                end else begin
                                                        frameIndex <= nextIndex;
                                                end
                                        end
                                end
                                scanDone: begin
                                        // hold the readings until go is released
                                        if (!go) begin
                                                state <= scanIdle;
                                        end
                                end
                                default: begin
                                        state <= scanIdle;
                                end
                        endcase
                end
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        for (int ch = 0; ch < numChannels; ch++) begin
                                readings[ch] <= '0;
                        end
                end else if (storeEnable) begin
                        for (int ch = 0; ch < numChannels; ch++) begin
                                if (storeIndex == channel_t'(ch)) begin
                                        readings[ch] <= sample;
                                end
                        end
                end
        end

        // frameEnd comes from the serial clock generator and may only arrive
        // while a frame is running
        frameInScan: assert property (@(posedge clock) disable iff (reset)
                frameEnd |-> state == scanFrame)
                else $error("frameEnd arrived outside a running frame");

endmodule

`default_nettype wire

// File: src/adcScanTop.sv
`timescale 1ns/1ps
`default_nettype none

module adcScanTop #(
        parameter int halfPeriodCycles = 4,
        parameter int numChannels = 8
) (
        input  logic clock,
        input  logic reset,
        input  logic go,
        input  logic dout,
        output logic sclk,
        output logic csN,
        output logic din,
        output logic done,
        output adcSerialPkg::sample_t readings [numChannels]
);
        import adcSerialPkg::*;

        logic fallStrobe;
        logic riseStrobe;
        logic frameEnd;
        logic load;
        channel_t loadAddress;
        sample_t sample;

        // serial clock and frame timing
        sclkGenerator #(
                .halfPeriodCycles(halfPeriodCycles)
        ) sclkGen (
                .clock(clock),
                .reset(reset),
                .csN(csN),
                .sclk(sclk),
                .fallStrobe(fallStrobe),
                .riseStrobe(riseStrobe),
                .frameEnd(frameEnd)
        );

        // address out on din, result in from dout
        frameShifter shifter (
                .clock(clock),
                .reset(reset),
                .load(load),
                .loadAddress(loadAddress),
                .fallStrobe(fallStrobe),
                .riseStrobe(riseStrobe),
                .dout(dout),
                .din(din),
                .sample(sample)
        );

        scanSequencer #(
                .numChannels(numChannels)
        ) sequencer (
                .clock(clock),
                .reset(reset),
                .go(go),
                .frameEnd(frameEnd),
                .sample(sample),
                .csN(csN),
                .done(done),
                .load(load),
                .loadAddress(loadAddress),
                .readings(readings)
        );

endmodule

`default_nettype wire

// File: testbench/adcSerialModel.sv
`timescale 1ns/1ps
`default_nettype none

// behavioural eight-channel converter on the serial pins
module adcSerialModel (
        input  logic csN,
        input  logic sclk,
        input  logic din,
        input  adcSerialPkg::sample_t channelValues [adcSerialPkg::maxChannels],
        output logic dout,
        output adcSerialPkg::channel_t addressLog [64],
        output int frameCount,
        output int selectCount,
        output int partialFrames,
        output int badDinFrames
);
        import adcSerialPkg::*;

        localparam int logDepth = 64;
        localparam int addressLsb = frameBits - addressMsb - channelBits;
        localparam logic [frameBits-1:0] addressMask =
                frameBits'((2 ** channelBits - 1) << addressLsb);

        int riseCount = 0;
        logic [frameBits-1:0] inShift = '0;
        channel_t prevAddress = '0;

        // din is taken on rising edges, sixteen of them close a frame
        initial begin
                for (int i = 0; i < logDepth; i++) begin
                        addressLog[i] = '0;
                end
                frameCount = 0;
                partialFrames = 0;
                badDinFrames = 0;
                forever begin
                        @(posedge sclk or posedge csN);
                        if (csN === 1'b1) begin
                                // a deselect in the middle of a frame loses that frame
                                if (riseCount != 0) begin
                                        partialFrames++;
                                end
                                riseCount = 0;
                                prevAddress = '0;
                        end else if (csN === 1'b0) begin
                                inShift = {inShift[frameBits-2:0], din};
                                riseCount++;
                                if (riseCount == frameBits) begin
                                        if ((inShift & ~addressMask) != '0) begin
                                                badDinFrames++;
                                        end
                                        if (frameCount < logDepth) begin
                                                addressLog[frameCount] =
                                                        inShift[addressLsb +: channelBits];
                                        end
                                        frameCount++;
                                        prevAddress = inShift[addressLsb +: channelBits];
                                        riseCount = 0;
                                end
                        end
                end
        end

        // four leading zeros, then the result of the previously addressed channel
        initial begin
                logic [frameBits-1:0] outWord;
                dout = 1'b0;
                selectCount = 0;
                forever begin
                        @(negedge csN or negedge sclk);
                        if (csN === 1'b0) begin
                                if (sclk === 1'b1) begin
                                        selectCount++;
                                end
                                outWord = {{(frameBits - sampleBits){1'b0}},
                                        channelValues[prevAddress]};
                                dout <= outWord[frameBits-1-riseCount];
                        end
                end
        end

endmodule

`default_nettype wire

// File: testbench/adcScanTb.sv
`timescale 1ns/1ps
`default_nettype none

module adcScanTb;
        import adcSerialPkg::*;

        localparam int numChannels = 8;
        localparam int halfPeriodCycles = 4;
        localparam int numRows = 4;
        localparam int framesPerScan = numChannels + 1;
        localparam int cyclesPerFrame = frameBits * 2 * halfPeriodCycles;
        localparam int scanCycles = framesPerScan * cyclesPerFrame;
        // twice the serial traffic of every row plus room for reset and handshakes
        localparam int timeoutNs = 2 * numRows * scanCycles * 10 + 2000;
        localparam int doneLimit = scanCycles + 100;
        localparam int holdCycles = 20;

        logic clock;
        logic reset;
        logic go;
        logic dout;
        logic sclk;
        logic csN;
        logic din;
        logic done;
        sample_t readings [numChannels];
        sample_t rowValues [maxChannels];
        sample_t stimTable [numRows][maxChannels];
        channel_t addressLog [64];
        int frameCount;
        int selectCount;
        int partialFrames;
        int badDinFrames;
        int idleViolations = 0;
        int errorCount;
        int testCount;
        int failedTests;
        integer seed;

        adcScanTop #(
                .halfPeriodCycles(halfPeriodCycles),
                .numChannels(numChannels)
        ) dut (
                .clock(clock),
                .reset(reset),
                .go(go),
                .dout(dout),
                .sclk(sclk),
                .csN(csN),
                .din(din),
                .done(done),
                .readings(readings)
        );

        adcSerialModel model (
                .csN(csN),
                .sclk(sclk),
                .din(din),
                .channelValues(rowValues),
                .dout(dout),
                .addressLog(addressLog),
                .frameCount(frameCount),
                .selectCount(selectCount),
                .partialFrames(partialFrames),
                .badDinFrames(badDinFrames)
        );

        always #5 clock = ~clock;

        // the serial clock must idle high whenever the converter is deselected
        always @(negedge clock) begin
                if (!reset && csN && !sclk) begin
                        idleViolations++;
                end
        end

        initial begin
                #(timeoutNs);
                $display("timeout after %0d ns, the scans never completed", timeoutNs);
                $display("TB FAILED");
                $finish;
        end

        task automatic checkValue(input string name, input logic [31:0] actual,
                        input logic [31:0] expected);
                if (actual !== expected) begin
                        $display("[FAIL] %0d ns %s: got %0h, expected %0h",
                                $time, name, actual, expected);
                        errorCount++;
                end
        endtask

        task automatic driveSlot();
                @(posedge clock);
                #1;
        endtask

        task automatic waitDone(input int limit);
                int count;
                count = 0;
                while (done !== 1'b1 && count < limit) begin
                        driveSlot();
                        count++;
                end
                if (done !== 1'b1) begin
                        $display("done did not rise within %0d cycles after go", limit);
                        errorCount++;
                end
        endtask

        task automatic checkReadings(input int row);
                for (int ch = 0; ch < numChannels; ch++) begin
                        checkValue($sformatf("readings[%0d]", ch), readings[ch],
                                stimTable[row][ch]);
                end
        endtask

        task automatic finishTest(input string title, input int errorsBefore);
                testCount++;
                if (errorCount == errorsBefore) begin
                        $display("test %0d %s: ok", testCount, title);
                end else begin
                        failedTests++;
                        $display("test %0d %s: %0d errors", testCount, title,
                                errorCount - errorsBefore);
                end
        endtask

        task automatic runScan(input int row);
                int framesBefore;
                int selectsBefore;
                int expectedAddress;
                framesBefore = frameCount;
                selectsBefore = selectCount;
                driveSlot();
                for (int ch = 0; ch < maxChannels; ch++) begin
                        rowValues[ch] = stimTable[row][ch];
                end
                go = 1'b1;
                waitDone(doneLimit);
                checkReadings(row);
                checkValue("frames per scan", frameCount - framesBefore, framesPerScan);
                checkValue("csN falls per scan", selectCount - selectsBefore, 1);
                // channels 0 to numChannels-1 in order, then channel 0 once more
                for (int f = 0; f < framesPerScan; f++) begin
                        expectedAddress = (f < numChannels) ? f : 0;
                        if (framesBefore + f < 64) begin
                                checkValue($sformatf("frame %0d address", f),
                                        addressLog[framesBefore + f], expectedAddress);
                        end
                end
                for (int c = 0; c < holdCycles; c++) begin
                        driveSlot();
                        checkValue("done", done, 1'b1);
                end
                checkReadings(row);
                go = 1'b0;
                driveSlot();
                checkValue("done", done, 1'b0);
                checkValue("csN", csN, 1'b1);
        endtask

        initial begin
                int errorsBefore;
                seed = 32'h3a9ea142;
                clock = 1'b0;
                reset = 1'b1;
                go = 1'b0;
                errorCount = 0;
                testCount = 0;
                failedTests = 0;
                for (int ch = 0; ch < maxChannels; ch++) begin
                        stimTable[0][ch] = '0;
                        stimTable[1][ch] = '1;
                        stimTable[2][ch] = sample_t'(12'h010 << ch);
                        stimTable[3][ch] = sample_t'($random(seed));
                        rowValues[ch] = '0;
                end
                repeat (5) @(posedge clock);
                #1;
                reset = 1'b0;

                errorsBefore = errorCount;
                checkValue("csN", csN, 1'b1);
                checkValue("sclk", sclk, 1'b1);
                checkValue("done", done, 1'b0);
                checkValue("din", din, 1'b0);
                for (int ch = 0; ch < numChannels; ch++) begin
                        checkValue($sformatf("readings[%0d]", ch), readings[ch], 0);
                end
                finishTest("reset state", errorsBefore);

                for (int row = 0; row < numRows; row++) begin
                        errorsBefore = errorCount;
                        runScan(row);
                        finishTest($sformatf("scan with row %0d", row), errorsBefore);
                end

                errorsBefore = errorCount;
                checkValue("partial frames", partialFrames, 0);
                checkValue("stray din bits", badDinFrames, 0);
                checkValue("sclk low while deselected", idleViolations, 0);
                finishTest("serial framing", errorsBefore);

                $display("%0d tests, %0d failed, %0d check errors",
                        testCount, failedTests, errorCount);
                if (errorCount == 0) begin
                        $display("TB PASSED");
                end else begin
                        $display("TB FAILED");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: adcScan.f
src/adcSerialPkg.sv
src/adcScanPkg.sv
src/sclkGenerator.sv
src/frameShifter.sv
src/scanSequencer.sv
src/adcScanTop.sv
testbench/adcSerialModel.sv
testbench/adcScanTb.sv

// File: Makefile
# Verilator build and run of the ADC scan controller testbench

VERILATOR ?= verilator
TOP ?= adcScanTb
FILELIST ?= adcScan.f
BUILD_DIR ?= obj_dir
PASS_STRING ?= TB PASSED
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulation output
run: compile
	@out="$$($(BINARY))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STRING)"

clean:
	rm -rf $(BUILD_DIR)
